// ==== include/difftest_params.svh ====
`ifndef DIFFTEST_PARAMS_SVH
`define DIFFTEST_PARAMS_SVH

// instruction word width
`define DT_INSN_DW      32

// word pc, byte offset bits dropped
`define DT_PC_W         30

// architectural register number width
`define DT_REG_AW       5

// register data width
`define DT_DW           32

// issue lanes
`define DT_LANES        2

// trace buffer entries, power of two
`define DT_TRACE_DEPTH  4

`endif

// ==== design/difftest_pkg.sv ====
`default_nettype none

`include "difftest_params.svh"

package difftest_pkg;

   typedef logic [`DT_INSN_DW-1:0] insn_t;
   typedef logic [`DT_PC_W-1:0]    pc_t;       // pc[31:2]
   typedef logic [`DT_REG_AW-1:0]  reg_addr_t;
   typedef logic [`DT_DW-1:0]      data_t;
   typedef logic [1:0]             cfg_addr_t;

   // trace register block map
   typedef enum cfg_addr_t
   {
      REG_CTRL    = 2'd0,   // bit0 enable, bit1 write 1 to clear overflow
      REG_STATUS  = 2'd1,   // bit0 overflow
      REG_COMMITS = 2'd2,
      REG_TSC     = 2'd3
   } cfg_reg_e;

endpackage

`default_nettype wire

// ==== design/commit_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

interface commit_if;
   import difftest_pkg::*;

   logic [`DT_LANES-1:0]       valid;   // one clock per committed lane
   pc_t [`DT_LANES-1:0]        pc;
   insn_t [`DT_LANES-1:0]      insn;
   logic [`DT_LANES-1:0]       we;
   reg_addr_t [`DT_LANES-1:0]  waddr;
   data_t [`DT_LANES-1:0]      wdata;

   modport src
   (
      output valid,
      output pc,
      output insn,
      output we,
      output waddr,
      output wdata
   );

   modport dst
   (
      input  valid,
      input  pc,
      input  insn,
      input  we,
      input  waddr,
      input  wdata
   );

endinterface

`default_nettype wire

// ==== design/insn_shadow_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module insn_shadow_pipe
(
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire                                   stall,
   input  wire                                   p_ce_s1,
   input  wire                                   p_ce_s2,
   input  wire                                   p_ce_s3,
   input  wire difftest_pkg::insn_t [`DT_LANES-1:0] id_ins,
   output difftest_pkg::insn_t [`DT_LANES-1:0]   cmt_ins
);
   import difftest_pkg::*;

   insn_t [`DT_LANES-1:0] ex_ins;
   insn_t [`DT_LANES-1:0] s1o_ins;
   insn_t [`DT_LANES-1:0] s2o_ins;
   insn_t [`DT_LANES-1:0] s3o_ins;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ex_ins  <= '0;
         s1o_ins <= '0;
         s2o_ins <= '0;
         s3o_ins <= '0;
         cmt_ins <= '0;
      end
      else
      begin
         if (!stall)
         begin
            ex_ins <= id_ins;      // decode -> execute
         end
         if (p_ce_s1)
         begin
            s1o_ins <= ex_ins;
         end
         if (p_ce_s2)
         begin
            s2o_ins <= s1o_ins;
         end
         if (p_ce_s3)
         begin
            s3o_ins <= s2o_ins;
         end
         cmt_ins <= s3o_ins;       // same stage as the commit bundle
      end
   end

endmodule

`default_nettype wire

// ==== design/commit_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module commit_stage
(
   input  wire                                       clk,
   input  wire                                       rst_n,
   input  wire                                       p_ce_s3,
   input  wire [`DT_LANES-1:0]                       commit_valid,
   input  wire difftest_pkg::pc_t [`DT_LANES-1:0]    commit_pc,
   input  wire [`DT_LANES-1:0]                       commit_rf_we,
   input  wire difftest_pkg::reg_addr_t [`DT_LANES-1:0] commit_rf_waddr,
   input  wire difftest_pkg::data_t [`DT_LANES-1:0]  commit_rf_wdata,
   input  wire difftest_pkg::insn_t [`DT_LANES-1:0]  cmt_ins,
   commit_if.src                                     cmt
);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cmt.valid <= '0;
         cmt.we    <= '0;
      end
      else
      begin
         cmt.valid <= commit_valid & {`DT_LANES{p_ce_s3}};   // no commit while s3 holds
         cmt.we    <= commit_rf_we;
      end
   end

   // payload, qualified by valid downstream
   always_ff @(posedge clk)
   begin
      cmt.pc    <= commit_pc;
      cmt.waddr <= commit_rf_waddr;
      cmt.wdata <= commit_rf_wdata;
   end

   assign cmt.insn = cmt_ins;   // shadow pipe output, already registered

endmodule

`default_nettype wire

// ==== design/arch_reg_shadow.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module arch_reg_shadow
(
   input  wire                           clk,
   input  wire                           rst_n,
   commit_if.dst                         cmt,
   input  wire difftest_pkg::reg_addr_t  dbg_raddr,
   output difftest_pkg::data_t           dbg_rdata
);
   import difftest_pkg::*;

   localparam NREGS = 1 << `DT_REG_AW;

   data_t regs [NREGS];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NREGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         // higher lane is younger, so it lands last
         for (int l = 0; l < `DT_LANES; l++)
         begin
            if (cmt.valid[l] && cmt.we[l] && (cmt.waddr[l] != '0))
            begin
               regs[cmt.waddr[l]] <= cmt.wdata[l];
            end
         end
      end
   end

   assign dbg_rdata = regs[dbg_raddr];   // r0 never written

endmodule

`default_nettype wire

// ==== design/trace_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module trace_serializer
(
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       trace_en,
   input  wire                       ovf_clear,
   commit_if.dst                     cmt,
   output logic                      trace_valid,
   output difftest_pkg::pc_t         trace_pc,
   output difftest_pkg::insn_t       trace_insn,
   output logic                      trace_wen,
   output difftest_pkg::reg_addr_t   trace_wnum,
   output difftest_pkg::data_t       trace_wdata,
   output logic                      trace_lane,
   output logic                      overflow
);
   import difftest_pkg::*;

   localparam DEPTH = `DT_TRACE_DEPTH;
   localparam PTR_W = $clog2(DEPTH);
   localparam CNT_W = $clog2(DEPTH + 1);

   pc_t        buf_pc    [DEPTH];
   insn_t      buf_insn  [DEPTH];
   logic       buf_wen   [DEPTH];
   reg_addr_t  buf_wnum  [DEPTH];
   data_t      buf_wdata [DEPTH];
   logic       buf_lane  [DEPTH];

   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] wr_ptr1;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] space;
   logic             pop;
   logic             push0;
   logic             push1;
   logic             drop;

   assign pop   = (count != '0);
   assign space = CNT_W'(DEPTH) - count + CNT_W'(pop);   // slot freed by this pop counts

   assign push0   = trace_en && cmt.valid[0] && (space != '0);
   assign push1   = trace_en && cmt.valid[1] && (space > CNT_W'(push0));
   assign drop    = trace_en && ((cmt.valid[0] && !push0) || (cmt.valid[1] && !push1));
   assign wr_ptr1 = wr_ptr + PTR_W'(push0);   // lane 1 goes behind lane 0

   always_ff @(posedge clk)
   begin
      if (push0)
      begin
         buf_pc[wr_ptr]    <= cmt.pc[0];
         buf_insn[wr_ptr]  <= cmt.insn[0];
         buf_wen[wr_ptr]   <= cmt.we[0];
         buf_wnum[wr_ptr]  <= cmt.waddr[0];
         buf_wdata[wr_ptr] <= cmt.wdata[0];
         buf_lane[wr_ptr]  <= 1'b0;
      end
      if (push1)
      begin
         buf_pc[wr_ptr1]    <= cmt.pc[1];
         buf_insn[wr_ptr1]  <= cmt.insn[1];
         buf_wen[wr_ptr1]   <= cmt.we[1];
         buf_wnum[wr_ptr1]  <= cmt.waddr[1];
         buf_wdata[wr_ptr1] <= cmt.wdata[1];
         buf_lane[wr_ptr1]  <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         rd_ptr <= rd_ptr + PTR_W'(pop);
         wr_ptr <= wr_ptr + PTR_W'(push0) + PTR_W'(push1);
         count  <= count - CNT_W'(pop) + CNT_W'(push0) + CNT_W'(push1);
         if (drop)
         begin
            overflow <= 1'b1;   // a new drop beats a clear
         end
         else if (ovf_clear)
         begin
            overflow <= 1'b0;
         end
      end
   end

   // head entry drives the record, popped every cycle it is valid
   assign trace_valid = pop;
   assign trace_pc    = buf_pc[rd_ptr];
   assign trace_insn  = buf_insn[rd_ptr];
   assign trace_wen   = buf_wen[rd_ptr];
   assign trace_wnum  = buf_wnum[rd_ptr];
   assign trace_wdata = buf_wdata[rd_ptr];
   assign trace_lane  = buf_lane[rd_ptr];

endmodule

`default_nettype wire

// ==== design/trace_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module trace_ctrl_regs
(
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           cfg_we,
   input  wire difftest_pkg::cfg_addr_t  cfg_addr,
   input  wire difftest_pkg::data_t      cfg_wdata,
   input  wire                           overflow,
   commit_if.dst                         cmt,
   output difftest_pkg::data_t           cfg_rdata,
   output logic                          trace_en,
   output logic                          ovf_clear
);
   import difftest_pkg::*;

   localparam NC_W = $clog2(`DT_LANES + 1);

   data_t           commits;
   data_t           tsc;
   logic [NC_W-1:0] n_commit;
   logic            ctrl_wr;

   assign ctrl_wr   = cfg_we && (cfg_reg_e'(cfg_addr) == REG_CTRL);
   assign ovf_clear = ctrl_wr && cfg_wdata[1];   // write-one pulse, not stored

   always_comb
   begin
      n_commit = '0;
      for (int l = 0; l < `DT_LANES; l++)
      begin
         n_commit = n_commit + NC_W'(cmt.valid[l]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         trace_en <= 1'b0;
         commits  <= '0;
         tsc      <= '0;
      end
      else
      begin
         if (ctrl_wr)
         begin
            trace_en <= cfg_wdata[0];
         end
         commits <= commits + data_t'(n_commit);   // independent of trace_en
         tsc     <= tsc + 1'b1;
      end
   end

   always_comb
   begin
      case (cfg_reg_e'(cfg_addr))
         REG_CTRL:    cfg_rdata = data_t'(trace_en);
         REG_STATUS:  cfg_rdata = data_t'(overflow);
         REG_COMMITS: cfg_rdata = commits;
         REG_TSC:     cfg_rdata = tsc;
         default:     cfg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/difftest_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module difftest_top
(
   input  wire                                          clk,
   input  wire                                          rst_n,
   input  wire                                          stall,
   input  wire                                          p_ce_s1,
   input  wire                                          p_ce_s2,
   input  wire                                          p_ce_s3,
   input  wire difftest_pkg::insn_t [`DT_LANES-1:0]     id_ins,
   input  wire [`DT_LANES-1:0]                          commit_valid,
   input  wire difftest_pkg::pc_t [`DT_LANES-1:0]       commit_pc,
   input  wire [`DT_LANES-1:0]                          commit_rf_we,
   input  wire difftest_pkg::reg_addr_t [`DT_LANES-1:0] commit_rf_waddr,
   input  wire difftest_pkg::data_t [`DT_LANES-1:0]     commit_rf_wdata,
   input  wire                                          cfg_we,
   input  wire difftest_pkg::cfg_addr_t                 cfg_addr,
   input  wire difftest_pkg::data_t                     cfg_wdata,
   input  wire difftest_pkg::reg_addr_t                 dbg_raddr,
   output wire                                          trace_valid,
   output wire difftest_pkg::pc_t                       trace_pc,
   output wire difftest_pkg::insn_t                     trace_insn,
   output wire                                          trace_wen,
   output wire difftest_pkg::reg_addr_t                 trace_wnum,
   output wire difftest_pkg::data_t                     trace_wdata,
   output wire                                          trace_lane,
   output wire                                          overflow,
   output wire difftest_pkg::data_t                     cfg_rdata,
   output wire difftest_pkg::data_t                     dbg_rdata
);
   import difftest_pkg::*;

   insn_t [`DT_LANES-1:0] cmt_ins;   // stage 3 word, one cycle later
   logic                  trace_en;
   logic                  ovf_clear;

   commit_if cmt ();   // registered commit bundle

   // port names match the nets here, so implicit connection by name
   insn_shadow_pipe u_insn_shadow_pipe
   (
      .*
   );

   commit_stage u_commit_stage
   (
      .*
   );

   arch_reg_shadow u_arch_reg_shadow
   (
      .*
   );

   trace_serializer u_trace_serializer
   (
      .*
   );

   trace_ctrl_regs u_trace_ctrl_regs
   (
      .*
   );

endmodule

`default_nettype wire

// ==== testbench/tb_difftest.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "difftest_params.svh"

module tb_difftest;
   import difftest_pkg::*;

   typedef struct packed
   {
      logic [2:0] test;
      logic       stall;
      logic [2:0] ce;      // {s3, s2, s1}
      logic [1:0] cv;
      logic [1:0] we;
      logic [4:0] wa0;
      logic [4:0] wa1;
      logic       cw;      // write to REG_CTRL
      logic [1:0] cd;
   } step_t;

   typedef struct packed
   {
      pc_t       pc;
      insn_t     insn;
      logic      wen;
      reg_addr_t wnum;
      data_t     wdata;
      logic      lane;
   } rec_t;

   logic                            clk;
   logic                            rst_n;
   logic                            stall;
   logic                            p_ce_s1;
   logic                            p_ce_s2;
   logic                            p_ce_s3;
   insn_t [`DT_LANES-1:0]           id_ins;
   logic [`DT_LANES-1:0]            commit_valid;
   pc_t [`DT_LANES-1:0]             commit_pc;
   logic [`DT_LANES-1:0]            commit_rf_we;
   reg_addr_t [`DT_LANES-1:0]       commit_rf_waddr;
   data_t [`DT_LANES-1:0]           commit_rf_wdata;
   logic                            cfg_we;
   cfg_addr_t                       cfg_addr;
   data_t                           cfg_wdata;
   reg_addr_t                       dbg_raddr;
   logic                            trace_valid;
   pc_t                             trace_pc;
   insn_t                           trace_insn;
   logic                            trace_wen;
   reg_addr_t                       trace_wnum;
   data_t                           trace_wdata;
   logic                            trace_lane;
   logic                            overflow;
   data_t                           cfg_rdata;
   data_t                           dbg_rdata;

   step_t                  steps [$];
   rec_t                   exp_q [$];   // records the buffer should emit in order
   insn_t [`DT_LANES-1:0]  m_ex;
   insn_t [`DT_LANES-1:0]  m_s1;
   insn_t [`DT_LANES-1:0]  m_s2;
   insn_t [`DT_LANES-1:0]  m_s3;
   logic [`DT_LANES-1:0]   c_valid;
   logic [`DT_LANES-1:0]   c_we;
   pc_t [`DT_LANES-1:0]    c_pc;
   insn_t [`DT_LANES-1:0]  c_insn;
   reg_addr_t [`DT_LANES-1:0] c_wa;
   data_t [`DT_LANES-1:0]  c_wd;
   data_t                  m_regs [32];
   data_t                  m_commits;
   int                     m_count;
   logic                   m_ovf;
   logic                   m_en;
   integer                 seed;
   string                  cur_name;
   int                     test_errs;
   int                     tests_run;
   int                     tests_bad;
   int                     n_checks;

   difftest_top UUT
   (
      .*
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic string test_name(input int t);
      case (t)
         0:       return "order_align";
         1:       return "stall_enables";
         2:       return "shadow_regs";
         3:       return "overflow";
         default: return "trace_off";
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      if (exp !== act)
      begin
         $display("error %s %s: expected %h actual %h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic add_step(input int t, input logic st, input logic [2:0] ce,
                           input logic [1:0] cv, input logic [1:0] we, input int wa0,
                           input int wa1, input logic cw, input logic [1:0] cd);
      step_t s;
      s.test  = 3'(t);
      s.stall = st;
      s.ce    = ce;
      s.cv    = cv;
      s.we    = we;
      s.wa0   = 5'(wa0);
      s.wa1   = 5'(wa1);
      s.cw    = cw;
      s.cd    = cd;
      steps.push_back(s);
   endtask

   task automatic add_idle(input int t, input int n);
      for (int k = 0; k < n; k++)
      begin
         add_step(t, 1'b1, 3'b000, 2'b00, 2'b00, 0, 0, 1'b0, 2'b00);
      end
   endtask

   task automatic build_table();
      add_step(0, 1, 3'b000, 2'b00, 2'b00, 0, 0, 1, 2'b01);   // trace on
      for (int k = 0; k < 8; k++)
      begin
         add_step(0, 0, 3'b111, 2'b11, 2'b11, 2 * k + 1, 2 * k + 2, 0, 2'b00);
         add_idle(0, 1);
      end
      add_step(1, 0, 3'b000, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 1, 3'b001, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 0, 3'b000, 2'b11, 2'b11, 3, 4, 0, 2'b00);   // gated while s3 holds
      add_step(1, 1, 3'b010, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 0, 3'b001, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 1, 3'b100, 2'b01, 2'b01, 17, 18, 0, 2'b00);
      add_step(1, 1, 3'b010, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 0, 3'b001, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 1, 3'b100, 2'b11, 2'b11, 19, 20, 0, 2'b00);
      add_step(1, 1, 3'b010, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 1, 3'b100, 2'b11, 2'b10, 21, 22, 0, 2'b00);
      add_step(1, 0, 3'b011, 2'b00, 2'b00, 0, 0, 0, 2'b00);
      add_step(1, 1, 3'b100, 2'b10, 2'b11, 23, 24, 0, 2'b00);
      add_step(2, 0, 3'b111, 2'b11, 2'b11, 5, 5, 0, 2'b00);    // same register
      add_idle(2, 1);
      add_step(2, 0, 3'b111, 2'b11, 2'b11, 0, 7, 0, 2'b00);
      add_idle(2, 1);
      add_step(2, 0, 3'b111, 2'b11, 2'b01, 9, 9, 0, 2'b00);
      add_idle(2, 1);
      add_step(2, 0, 3'b111, 2'b10, 2'b11, 10, 11, 0, 2'b00);
      add_idle(2, 1);
      add_step(2, 0, 3'b111, 2'b11, 2'b11, 0, 0, 0, 2'b00);
      for (int k = 0; k < 5; k++)
      begin
         add_step(3, 0, 3'b111, 2'b11, 2'b11, 12 + k, 25 + k, 0, 2'b00);
      end
      add_idle(3, 6);
      add_step(3, 1, 3'b000, 2'b00, 2'b00, 0, 0, 1, 2'b11);   // clear overflow and stay enabled
      add_step(4, 0, 3'b111, 2'b11, 2'b11, 20, 21, 0, 2'b00);
      add_step(4, 0, 3'b111, 2'b11, 2'b11, 22, 23, 1, 2'b00);  // trace off
      add_step(4, 0, 3'b111, 2'b11, 2'b11, 24, 25, 0, 2'b00);
      add_step(4, 0, 3'b111, 2'b01, 2'b01, 26, 27, 0, 2'b00);
   endtask

   task automatic apply_step(input step_t s);
      stall                      = s.stall;
      {p_ce_s3, p_ce_s2, p_ce_s1} = s.ce;
      commit_valid               = s.cv;
      commit_rf_we               = s.we;
      commit_rf_waddr[0]         = s.wa0;
      commit_rf_waddr[1]         = s.wa1;
      cfg_we                     = s.cw;
      cfg_addr                   = REG_CTRL;
      cfg_wdata                  = 32'(s.cd);
      for (int l = 0; l < `DT_LANES; l++)
      begin
         id_ins[l]          = $random(seed);
         commit_pc[l]       = pc_t'($random(seed));
         commit_rf_wdata[l] = $random(seed);
      end
   endtask

   // pipeline, commit register, buffer and counters as seen at each edge
   always @(posedge clk)
   begin : ref_model
      rec_t r;
      int   space;
      logic pop;
      logic drop;
      if (!rst_n)
      begin
         m_ex      = '0;
         m_s1      = '0;
         m_s2      = '0;
         m_s3      = '0;
         c_valid   = '0;
         c_we      = '0;
         m_count   = 0;
         m_ovf     = 1'b0;
         m_en      = 1'b0;
         m_commits = '0;
         for (int i = 0; i < 32; i++)
         begin
            m_regs[i] = '0;
         end
         exp_q.delete();
      end
      else
      begin
         pop   = (m_count != 0);
         space = `DT_TRACE_DEPTH - m_count + (pop ? 1 : 0);   // slot freed by the pop
         drop  = 1'b0;
         for (int l = 0; l < `DT_LANES; l++)
         begin
            if (m_en && c_valid[l])
            begin
               if (space > 0)
               begin
                  r.pc    = c_pc[l];
                  r.insn  = c_insn[l];
                  r.wen   = c_we[l];
                  r.wnum  = c_wa[l];
                  r.wdata = c_wd[l];
                  r.lane  = 1'(l);
                  exp_q.push_back(r);
                  m_count++;
                  space--;
               end
               else
               begin
                  drop = 1'b1;
               end
            end
         end
         if (pop)
         begin
            m_count--;
         end
         if (drop)
         begin
            m_ovf = 1'b1;
         end
         else if (cfg_we && cfg_addr == REG_CTRL && cfg_wdata[1])
         begin
            m_ovf = 1'b0;
         end
         for (int l = 0; l < `DT_LANES; l++)
         begin
            if (c_valid[l] && c_we[l] && c_wa[l] != '0)
            begin
               m_regs[c_wa[l]] = c_wd[l];   // lane 1 lands last
            end
         end
         m_commits = m_commits + data_t'(c_valid[0]) + data_t'(c_valid[1]);
         if (cfg_we && cfg_addr == REG_CTRL)
         begin
            m_en = cfg_wdata[0];
         end
         c_valid = commit_valid & {`DT_LANES{p_ce_s3}};
         c_we    = commit_rf_we;
         c_pc    = commit_pc;
         c_wa    = commit_rf_waddr;
         c_wd    = commit_rf_wdata;
         c_insn  = m_s3;   // word leaving s3 belongs to this commit
         if (p_ce_s3)
         begin
            m_s3 = m_s2;
         end
         if (p_ce_s2)
         begin
            m_s2 = m_s1;
         end
         if (p_ce_s1)
         begin
            m_s1 = m_ex;
         end
         if (!stall)
         begin
            m_ex = id_ins;
         end
      end
   end

   always @(negedge clk)
   begin : trace_monitor
      rec_t r;
      if (rst_n)
      begin
         check_value("trace_valid", 32'(exp_q.size() != 0), 32'(trace_valid));
         check_value("overflow", 32'(m_ovf), 32'(overflow));
         if (trace_valid && exp_q.size() != 0)
         begin
            r = exp_q.pop_front();
            check_value("trace_pc", 32'(r.pc), 32'(trace_pc));
            check_value("trace_insn", r.insn, trace_insn);
            check_value("trace_wen", 32'(r.wen), 32'(trace_wen));
            check_value("trace_wnum", 32'(r.wnum), 32'(trace_wnum));
            check_value("trace_wdata", r.wdata, trace_wdata);
            check_value("trace_lane", 32'(r.lane), 32'(trace_lane));
         end
      end
   end

   task automatic finish_test(input int t);
      data_t tsc0;
      step_t idle;
      idle       = '0;
      idle.stall = 1'b1;
      apply_step(idle);
      cfg_addr = REG_TSC;
      #1;
      tsc0 = cfg_rdata;
      repeat (8) @(posedge clk);   // drains the buffer
      #1;
      check_value("tsc delta", 32'd8, cfg_rdata - tsc0);
      for (int r = 0; r < 32; r++)
      begin
         dbg_raddr = reg_addr_t'(r);
         #2;
         check_value($sformatf("r%0d", r), m_regs[r], dbg_rdata);
         @(posedge clk);
         #1;
      end
      cfg_addr = REG_COMMITS;
      #2;
      check_value("commits", m_commits, cfg_rdata);
      @(posedge clk);
      #1;
      cfg_addr = REG_STATUS;
      #2;
      check_value("status", 32'(m_ovf), cfg_rdata);
      @(posedge clk);
      #1;
      cfg_addr = REG_CTRL;
      #2;
      check_value("trace enable", 32'(m_en), cfg_rdata);
      if (exp_q.size() != 0)
      begin
         $display("test %s: %0d trace records never came out", cur_name, exp_q.size());
         test_errs++;
      end
      $display("test %0d %s: %0d errors", t, cur_name, test_errs);
      tests_run++;
      if (test_errs != 0)
      begin
         tests_bad++;
      end
      test_errs = 0;
      @(posedge clk);
      #1;
   endtask

   initial
   begin : main
      int t;
      seed            = 68;
      rst_n           = 1'b0;
      stall           = 1'b1;
      p_ce_s1         = 1'b0;
      p_ce_s2         = 1'b0;
      p_ce_s3         = 1'b0;
      id_ins          = '0;
      commit_valid    = '0;
      commit_pc       = '0;
      commit_rf_we    = '0;
      commit_rf_waddr = '0;
      commit_rf_wdata = '0;
      cfg_we          = 1'b0;
      cfg_addr        = REG_CTRL;
      cfg_wdata       = '0;
      dbg_raddr       = '0;
      test_errs       = 0;
      tests_run       = 0;
      tests_bad       = 0;
      n_checks        = 0;
      build_table();
      repeat (4) @(posedge clk);
      #1;
      rst_n    = 1'b1;
      t        = 0;
      cur_name = test_name(0);
      for (int i = 0; i < steps.size(); i++)
      begin
         if (int'(steps[i].test) != t)
         begin
            finish_test(t);
            t        = int'(steps[i].test);
            cur_name = test_name(t);
         end
         apply_step(steps[i]);
         @(posedge clk);
         #1;
      end
      finish_test(t);
      $display("%0d tests run, %0d clean, %0d with errors, %0d checks",
               tests_run, tests_run - tests_bad, tests_bad, n_checks);
      if (tests_bad == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

   initial
   begin : watchdog
      #1;
      repeat (steps.size() * 20) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles", steps.size() * 20);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== difftest.f ====
+incdir+include
design/difftest_pkg.sv
design/commit_if.sv
design/insn_shadow_pipe.sv
design/commit_stage.sv
design/arch_reg_shadow.sv
design/trace_serializer.sv
design/trace_ctrl_regs.sv
design/difftest_top.sv
testbench/tb_difftest.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log

verilator --binary --timing -Wno-fatal -f difftest.f --top-module tb_difftest \
   && ./obj_dir/Vtb_difftest > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "tests failed" sim.log && exit 1 || exit 0
